// ==== Bender.yml ====
package:
  name: rv_frontend

sources:
  - design/rv_pkg.sv
  - design/sync_fifo.sv
  - design/fetch_unit.sv
  - design/decoder.sv
  - design/frontend_top.sv
  - target: test
    files:
      - testbench/frontend_props.sv
      - testbench/frontend_checker.sv
      - testbench/frontend_tb.sv

// ==== design/decoder.sv ====
/*
 * combinational RV32IM decode of one fetched word
 * loads, stores and branches are only sorted by functional unit
 * flags read low while in_valid is low, other fields still follow the word
 */
`default_nettype none

module decoder (
	input  logic                  in_valid,
	input  rv_pkg::fetch_pack_t   in_fetch,
	output rv_pkg::decoded_pack_t decoded_pack
);

	rv_pkg::inst_t inst;
	logic [rv_pkg::xlen-1:0] i_imm;
	logic [rv_pkg::xlen-1:0] s_imm;
	logic [rv_pkg::xlen-1:0] b_imm;
	logic [rv_pkg::xlen-1:0] u_imm;
	logic [rv_pkg::xlen-1:0] j_imm;

	assign inst = in_fetch.inst;

	// sign extended immediates, b and j have bit 0 clear
	assign i_imm = {{20{inst.raw[31]}}, inst.raw[31:20]};
	assign s_imm = {{20{inst.raw[31]}}, inst.raw[31:25], inst.raw[11:7]};
	assign b_imm = {{19{inst.raw[31]}}, inst.raw[31], inst.raw[7], inst.raw[30:25],
		inst.raw[11:8], 1'b0};
	assign u_imm = {inst.raw[31:12], 12'b0};
	assign j_imm = {{11{inst.raw[31]}}, inst.raw[31], inst.raw[19:12], inst.raw[20],
		inst.raw[30:21], 1'b0};

	always_comb begin
		// defaults amount to a nop on the alu
		decoded_pack = '0;
		decoded_pack.pc = in_fetch.pc;
		decoded_pack.fu = rv_pkg::fu_alu;
		decoded_pack.alu_func = rv_pkg::alu_add;

		// fields and unit by instruction class
		casez (inst.raw)
			rv_pkg::rv32_lui, rv_pkg::rv32_auipc: begin
				decoded_pack.arch_reg.dest = inst.r.rd;
				decoded_pack.imm = u_imm;
			end
			rv_pkg::rv32_jal: begin
				decoded_pack.arch_reg.dest = inst.r.rd;
				decoded_pack.imm = j_imm;
				decoded_pack.fu = rv_pkg::fu_branch;
			end
			rv_pkg::rv32_jalr: begin
				decoded_pack.arch_reg.dest = inst.r.rd;
				decoded_pack.imm = i_imm;
				decoded_pack.fu = rv_pkg::fu_branch;
			end
			rv_pkg::rv32_beq, rv_pkg::rv32_bne, rv_pkg::rv32_blt,
			rv_pkg::rv32_bge, rv_pkg::rv32_bltu, rv_pkg::rv32_bgeu: begin
				decoded_pack.arch_reg.src1 = inst.r.rs1;
				decoded_pack.arch_reg.src2 = inst.r.rs2;
				decoded_pack.imm = b_imm;
				decoded_pack.fu = rv_pkg::fu_branch;
			end
			rv_pkg::rv32_lb, rv_pkg::rv32_lh, rv_pkg::rv32_lw,
			rv_pkg::rv32_lbu, rv_pkg::rv32_lhu: begin
				decoded_pack.arch_reg.dest = inst.r.rd;
				decoded_pack.arch_reg.src1 = inst.r.rs1;
				decoded_pack.imm = i_imm;
				decoded_pack.fu = rv_pkg::fu_mem;
			end
			rv_pkg::rv32_sb, rv_pkg::rv32_sh, rv_pkg::rv32_sw: begin
				decoded_pack.arch_reg.src1 = inst.r.rs1;
				decoded_pack.arch_reg.src2 = inst.r.rs2;
				decoded_pack.imm = s_imm;
				decoded_pack.fu = rv_pkg::fu_mem;
			end
			// shift immediates keep funct7 in the upper imm bits
			rv_pkg::rv32_addi, rv_pkg::rv32_slti, rv_pkg::rv32_sltiu,
			rv_pkg::rv32_xori, rv_pkg::rv32_ori, rv_pkg::rv32_andi,
			rv_pkg::rv32_slli, rv_pkg::rv32_srli, rv_pkg::rv32_srai: begin
				decoded_pack.arch_reg.dest = inst.r.rd;
				decoded_pack.arch_reg.src1 = inst.r.rs1;
				decoded_pack.imm = i_imm;
			end
			rv_pkg::rv32_add, rv_pkg::rv32_sub, rv_pkg::rv32_sll,
			rv_pkg::rv32_slt, rv_pkg::rv32_sltu, rv_pkg::rv32_xor,
			rv_pkg::rv32_srl, rv_pkg::rv32_sra, rv_pkg::rv32_or,
			rv_pkg::rv32_and: begin
				decoded_pack.arch_reg = '{src1: inst.r.rs1, src2: inst.r.rs2, dest: inst.r.rd};
			end
			rv_pkg::rv32_mul, rv_pkg::rv32_mulh,
			rv_pkg::rv32_mulhsu, rv_pkg::rv32_mulhu: begin
				decoded_pack.arch_reg = '{src1: inst.r.rs1, src2: inst.r.rs2, dest: inst.r.rd};
				decoded_pack.fu = rv_pkg::fu_mult;
			end
			rv_pkg::rv32_csrrw, rv_pkg::rv32_csrrs, rv_pkg::rv32_csrrc:
				decoded_pack.csr_op = 1'b1;
			rv_pkg::rv32_wfi:
				decoded_pack.halt = 1'b1;
			default:
				decoded_pack.illegal = 1'b1;
		endcase

		// operation, the same for immediate and register forms
		casez (inst.raw)
			rv_pkg::rv32_sub: decoded_pack.alu_func = rv_pkg::alu_sub;
			rv_pkg::rv32_slt, rv_pkg::rv32_slti: decoded_pack.alu_func = rv_pkg::alu_slt;
			rv_pkg::rv32_sltu, rv_pkg::rv32_sltiu: decoded_pack.alu_func = rv_pkg::alu_sltu;
			rv_pkg::rv32_and, rv_pkg::rv32_andi: decoded_pack.alu_func = rv_pkg::alu_and;
			rv_pkg::rv32_or, rv_pkg::rv32_ori: decoded_pack.alu_func = rv_pkg::alu_or;
			rv_pkg::rv32_xor, rv_pkg::rv32_xori: decoded_pack.alu_func = rv_pkg::alu_xor;
			rv_pkg::rv32_sll, rv_pkg::rv32_slli: decoded_pack.alu_func = rv_pkg::alu_sll;
			rv_pkg::rv32_srl, rv_pkg::rv32_srli: decoded_pack.alu_func = rv_pkg::alu_srl;
			rv_pkg::rv32_sra, rv_pkg::rv32_srai: decoded_pack.alu_func = rv_pkg::alu_sra;
			rv_pkg::rv32_mul: decoded_pack.alu_func = rv_pkg::mult_mul;
			rv_pkg::rv32_mulh: decoded_pack.alu_func = rv_pkg::mult_mulh;
			rv_pkg::rv32_mulhsu: decoded_pack.alu_func = rv_pkg::mult_mulhsu;
			rv_pkg::rv32_mulhu: decoded_pack.alu_func = rv_pkg::mult_mulhu;
			default: decoded_pack.alu_func = rv_pkg::alu_add;
		endcase

		// no flag from an empty fetch queue head
		if (!in_valid) begin
			decoded_pack.halt = 1'b0;
			decoded_pack.csr_op = 1'b0;
			decoded_pack.illegal = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
/*
 * wishbone classic master with one request in flight, no writes
 * adr is a byte address, pc steps by four per request
 * a flush or halt squashes the request in flight, its data is dropped
 */
`default_nettype none

module fetch_unit (
	input  logic                          clk,
	input  logic                          arst_n,
	input  rv_pkg::wb_rsp_t               wb_rsp,
	input  logic                          fifo_full,
	input  logic                          halt_seen,
	input  logic                          flush,
	input  logic [rv_pkg::xlen-1:0]       redirect_pc,
	output rv_pkg::wb_req_t               wb_req,
	output logic                          fetch_push,
	output rv_pkg::fetch_pack_t           fetch_data,
	output logic                          fetch_clear,
	output logic                          halted
);

	logic [rv_pkg::xlen-1:0] pc;
	logic [rv_pkg::xlen-1:0] req_adr;
	logic busy;
	logic squash;
	logic ack;
	logic issue;

	// ack only counts while a request is open
	assign ack = busy & wb_rsp.ack;
	assign fetch_clear = flush | halt_seen;

	// busy drops the cycle after ack, so the idle cycle comes for free
	assign issue = ~busy & ~fifo_full & ~halted & ~fetch_clear;
	assign fetch_push = ack & ~squash & ~fetch_clear;

	assign wb_req = '{cyc: busy, stb: busy, adr: req_adr};
	assign fetch_data = '{inst: wb_rsp.dat, pc: req_adr};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= rv_pkg::reset_pc;
			req_adr <= rv_pkg::reset_pc;
			busy <= 1'b0;
			squash <= 1'b0;
			halted <= 1'b0;
		end else begin
			if (issue) begin
				busy <= 1'b1;
				req_adr <= pc;
				pc <= pc + rv_pkg::xlen'(4);
			end else if (ack) begin
				busy <= 1'b0;
			end
			// stale request still runs to its ack
			if (ack)
				squash <= 1'b0;
			else if (busy && fetch_clear)
				squash <= 1'b1;
			// flush beats halt, so a flush in the halt cycle resumes fetch
			if (flush) begin
				pc <= redirect_pc;
				halted <= 1'b0;
			end else if (halt_seen) begin
				halted <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/frontend_top.sv ====
/*
 * fetch unit, fetch queue, decoder and decode queue in a row
 * dispatch_valid is the decode queue not empty, transfer on valid and ready
 * a flush clears both queues in one cycle
 */
`default_nettype none

module frontend_top (
	input  logic                    clk,
	input  logic                    arst_n,
	input  rv_pkg::wb_rsp_t         wb_rsp,
	input  logic                    flush,
	input  logic [rv_pkg::xlen-1:0] redirect_pc,
	input  logic                    dispatch_ready,
	output rv_pkg::wb_req_t         wb_req,
	output rv_pkg::decoded_pack_t   dispatch_pack,
	output logic                    dispatch_valid,
	output logic                    halted
);

	rv_pkg::fetch_pack_t fetch_data;
	rv_pkg::fetch_pack_t fetch_head;
	rv_pkg::decoded_pack_t decoded;
	logic fetch_push;
	logic fetch_clear;
	logic fetch_empty;
	logic fetch_full;
	logic decode_empty;
	logic decode_full;
	logic xfer;
	logic halt_seen;

	// head moves from fetch queue to decode queue in one cycle
	assign xfer = ~fetch_empty & ~decode_full;
	// decoder flags are already low on an empty head
	assign halt_seen = decoded.halt & ~decode_full;
	assign dispatch_valid = ~decode_empty;

	fetch_unit fetch_unit0 (
		.clk, .arst_n, .wb_rsp, .fifo_full(fetch_full), .halt_seen,
		.flush, .redirect_pc, .wb_req, .fetch_push, .fetch_data,
		.fetch_clear, .halted
	);

	sync_fifo #(.T(rv_pkg::fetch_pack_t), .DEPTH(rv_pkg::fetch_depth)) fetch_q0 (
		.clk, .arst_n, .clear(fetch_clear), .push(fetch_push), .push_data(fetch_data),
		.pop(xfer), .pop_data(fetch_head), .empty(fetch_empty), .full(fetch_full)
	);

	decoder decoder0 (
		.in_valid(~fetch_empty), .in_fetch(fetch_head), .decoded_pack(decoded)
	);

	// halt packet still enters here, only the fetch side is cleared
	sync_fifo #(.T(rv_pkg::decoded_pack_t), .DEPTH(rv_pkg::decode_depth)) decode_q0 (
		.clk, .arst_n, .clear(flush), .push(xfer), .push_data(decoded),
		.pop(dispatch_ready), .pop_data(dispatch_pack), .empty(decode_empty),
		.full(decode_full)
	);

endmodule

`default_nettype wire

// ==== design/rv_pkg.sv ====
/*
 * shared types and constants of the RV32IM front end
 * opcode patterns hold ? bits and are meant for casez only
 * wishbone adr carries the byte address of a 32-bit word
 */
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;
	localparam logic [xlen-1:0] reset_pc = '0;
	localparam int fetch_depth = 4;
	localparam int decode_depth = 4;

	typedef logic [4:0] reg_addr_t;

	// raw word or R-format view
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [6:0] funct7;
			reg_addr_t  rs2;
			reg_addr_t  rs1;
			logic [2:0] funct3;
			reg_addr_t  rd;
			logic [6:0] opcode;
		} r;
	} inst_t;

	typedef enum logic [1:0] {
		fu_alu,
		fu_mult,
		fu_mem,
		fu_branch
	} fu_e;

	// multiply variants share the code space with the alu ops
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or, alu_xor,
		alu_sll, alu_srl, alu_sra, mult_mul, mult_mulh, mult_mulhsu, mult_mulhu
	} alu_func_e;

	typedef struct packed {
		reg_addr_t src1;
		reg_addr_t src2;
		reg_addr_t dest;
	} arch_reg_t;

	typedef struct packed {
		inst_t            inst;
		logic [xlen-1:0]  pc;
	} fetch_pack_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		fu_e             fu;
		arch_reg_t       arch_reg;
		logic [xlen-1:0] imm;
		alu_func_e       alu_func;
		logic            halt;
		logic            csr_op;
		logic            illegal;
	} decoded_pack_t;

	typedef struct packed {
		logic            cyc;
		logic            stb;
		logic [xlen-1:0] adr;
	} wb_req_t;

	typedef struct packed {
		logic            ack;
		logic [xlen-1:0] dat;
	} wb_rsp_t;

	// funct7 rs2 rs1 funct3 rd opcode
	localparam logic [31:0] rv32_lui    = 32'b???????_?????_?????_???_?????_0110111;
	localparam logic [31:0] rv32_auipc  = 32'b???????_?????_?????_???_?????_0010111;
	localparam logic [31:0] rv32_jal    = 32'b???????_?????_?????_???_?????_1101111;
	localparam logic [31:0] rv32_jalr   = 32'b???????_?????_?????_000_?????_1100111;
	localparam logic [31:0] rv32_beq    = 32'b???????_?????_?????_000_?????_1100011;
	localparam logic [31:0] rv32_bne    = 32'b???????_?????_?????_001_?????_1100011;
	localparam logic [31:0] rv32_blt    = 32'b???????_?????_?????_100_?????_1100011;
	localparam logic [31:0] rv32_bge    = 32'b???????_?????_?????_101_?????_1100011;
	localparam logic [31:0] rv32_bltu   = 32'b???????_?????_?????_110_?????_1100011;
	localparam logic [31:0] rv32_bgeu   = 32'b???????_?????_?????_111_?????_1100011;
	localparam logic [31:0] rv32_lb     = 32'b???????_?????_?????_000_?????_0000011;
	localparam logic [31:0] rv32_lh     = 32'b???????_?????_?????_001_?????_0000011;
	localparam logic [31:0] rv32_lw     = 32'b???????_?????_?????_010_?????_0000011;
	localparam logic [31:0] rv32_lbu    = 32'b???????_?????_?????_100_?????_0000011;
	localparam logic [31:0] rv32_lhu    = 32'b???????_?????_?????_101_?????_0000011;
	localparam logic [31:0] rv32_sb     = 32'b???????_?????_?????_000_?????_0100011;
	localparam logic [31:0] rv32_sh     = 32'b???????_?????_?????_001_?????_0100011;
	localparam logic [31:0] rv32_sw     = 32'b???????_?????_?????_010_?????_0100011;
	localparam logic [31:0] rv32_addi   = 32'b???????_?????_?????_000_?????_0010011;
	localparam logic [31:0] rv32_slti   = 32'b???????_?????_?????_010_?????_0010011;
	localparam logic [31:0] rv32_sltiu  = 32'b???????_?????_?????_011_?????_0010011;
	localparam logic [31:0] rv32_xori   = 32'b???????_?????_?????_100_?????_0010011;
	localparam logic [31:0] rv32_ori    = 32'b???????_?????_?????_110_?????_0010011;
	localparam logic [31:0] rv32_andi   = 32'b???????_?????_?????_111_?????_0010011;
	localparam logic [31:0] rv32_slli   = 32'b0000000_?????_?????_001_?????_0010011;
	localparam logic [31:0] rv32_srli   = 32'b0000000_?????_?????_101_?????_0010011;
	localparam logic [31:0] rv32_srai   = 32'b0100000_?????_?????_101_?????_0010011;
	localparam logic [31:0] rv32_add    = 32'b0000000_?????_?????_000_?????_0110011;
	localparam logic [31:0] rv32_sub    = 32'b0100000_?????_?????_000_?????_0110011;
	localparam logic [31:0] rv32_sll    = 32'b0000000_?????_?????_001_?????_0110011;
	localparam logic [31:0] rv32_slt    = 32'b0000000_?????_?????_010_?????_0110011;
	localparam logic [31:0] rv32_sltu   = 32'b0000000_?????_?????_011_?????_0110011;
	localparam logic [31:0] rv32_xor    = 32'b0000000_?????_?????_100_?????_0110011;
	localparam logic [31:0] rv32_srl    = 32'b0000000_?????_?????_101_?????_0110011;
	localparam logic [31:0] rv32_sra    = 32'b0100000_?????_?????_101_?????_0110011;
	localparam logic [31:0] rv32_or     = 32'b0000000_?????_?????_110_?????_0110011;
	localparam logic [31:0] rv32_and    = 32'b0000000_?????_?????_111_?????_0110011;
	localparam logic [31:0] rv32_mul    = 32'b0000001_?????_?????_000_?????_0110011;
	localparam logic [31:0] rv32_mulh   = 32'b0000001_?????_?????_001_?????_0110011;
	localparam logic [31:0] rv32_mulhsu = 32'b0000001_?????_?????_010_?????_0110011;
	localparam logic [31:0] rv32_mulhu  = 32'b0000001_?????_?????_011_?????_0110011;
	localparam logic [31:0] rv32_csrrw  = 32'b???????_?????_?????_001_?????_1110011;
	localparam logic [31:0] rv32_csrrs  = 32'b???????_?????_?????_010_?????_1110011;
	localparam logic [31:0] rv32_csrrc  = 32'b???????_?????_?????_011_?????_1110011;
	// exact encoding, no don't-care bits
	localparam logic [31:0] rv32_wfi    = 32'b0001000_00101_00000_000_00000_1110011;

endpackage

`default_nettype wire

// ==== design/sync_fifo.sv ====
/*
 * circular queue, head entry is shown on pop_data while empty is low
 * clear beats a push in the same cycle
 * DEPTH of 2 or more
 */
`default_nettype none

module sync_fifo #(
	parameter type T = logic,
	parameter int DEPTH = 4
) (
	input  logic clk,
	input  logic arst_n,
	input  logic clear,
	input  logic push,
	input  T     push_data,
	input  logic pop,
	output T     pop_data,
	output logic empty,
	output logic full
);

	T mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic do_push;
	logic do_pop;

	// requests are ignored at the limits
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	assign empty = (count == 0);
	assign full = (count == DEPTH);
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else if (clear) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			// pointers wrap at DEPTH, not at a power of two
			if (do_push)
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage only, pointers decide what is valid
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
design/rv_pkg.sv
design/sync_fifo.sv
design/fetch_unit.sv
design/decoder.sv
design/frontend_top.sv
testbench/frontend_props.sv
testbench/frontend_checker.sv
testbench/frontend_tb.sv

// ==== testbench/frontend_checker.sv ====
/*
 * compares every dispatch transfer with the expected list, in order
 * also watches halt, no transfer and no new request until a flush
 */
`default_nettype none

module frontend_checker (
	input wire logic                  clk,
	input wire logic                  arst_n,
	input wire rv_pkg::decoded_pack_t dispatch_pack,
	input wire logic                  dispatch_valid,
	input wire logic                  dispatch_ready,
	input wire logic                  halted,
	input wire logic                  flush,
	input wire rv_pkg::wb_req_t       wb_req
);
	timeunit 1ns;
	timeprecision 1ps;

	rv_pkg::decoded_pack_t expected [$];
	int errors = 0;
	int tests = 0;
	int passed = 0;
	logic cyc_q = 1'b0;
	logic after_halt = 1'b0;

	task automatic add_expected(input rv_pkg::decoded_pack_t rec);
		expected.push_back(rec);
	endtask

	function automatic int pending();
		return expected.size();
	endfunction

	// field by field, one line per test
	task automatic compare(input rv_pkg::decoded_pack_t got);
		rv_pkg::decoded_pack_t exp;
		bit ok;
		exp = expected.pop_front();
		tests++;
		ok = (got.pc == exp.pc) && (got.fu == exp.fu) && (got.arch_reg == exp.arch_reg) &&
			(got.imm == exp.imm) && (got.alu_func == exp.alu_func) && (got.halt == exp.halt) &&
			(got.csr_op == exp.csr_op) && (got.illegal == exp.illegal);
		if (ok) begin
			passed++;
			$display("test %0d pc %h ok", tests, got.pc);
		end else begin
			errors++;
			$display("Fail %0t: test %0d pc %h/%h fu %0d/%0d regs %h/%h imm %h/%h op %0d/%0d",
				$time, tests, got.pc, exp.pc, got.fu, exp.fu, got.arch_reg, exp.arch_reg,
				got.imm, exp.imm, got.alu_func, exp.alu_func);
			$display("Fail %0t: test %0d flags halt csr illegal %b%b%b expected %b%b%b",
				$time, tests, got.halt, got.csr_op, got.illegal, exp.halt, exp.csr_op,
				exp.illegal);
		end
	endtask

	always @(posedge clk) begin
		if (arst_n) begin
			// new wishbone request while halted
			if (wb_req.cyc && !cyc_q && halted) begin
				errors++;
				$display("error at %0t: fetch issued a bus request while halted", $time);
			end
			if (dispatch_valid && dispatch_ready) begin
				if (after_halt) begin
					errors++;
					$display("error at %0t: packet pc %h dispatched after a halt",
						$time, dispatch_pack.pc);
				end else if (expected.size() == 0) begin
					errors++;
					$display("error at %0t: unexpected extra packet pc %h",
						$time, dispatch_pack.pc);
				end else begin
					compare(dispatch_pack);
				end
				if (dispatch_pack.halt) begin
					after_halt = 1'b1;
					if (!halted) begin
						errors++;
						$display("error at %0t: halted low when the wfi packet left", $time);
					end
				end
			end
			if (flush)
				after_halt = 1'b0;
		end
		cyc_q = wb_req.cyc;
	end

	task automatic report();
		if (expected.size() != 0) begin
			errors++;
			$display("error: %0d expected packets never dispatched", expected.size());
		end
		$display("tests %0d passed %0d errors %0d", tests, passed, errors);
	endtask

endmodule

`default_nettype wire

// ==== testbench/frontend_props.sv ====
/*
 * handshake assertions, bound into the frontend top level
 * wishbone adr is checked only while stb waits for ack
 */
`default_nettype none

module frontend_props (
	input wire logic                  clk,
	input wire logic                  arst_n,
	input wire rv_pkg::wb_req_t       wb_req,
	input wire rv_pkg::wb_rsp_t       wb_rsp,
	input wire rv_pkg::decoded_pack_t dispatch_pack,
	input wire logic                  dispatch_valid,
	input wire logic                  dispatch_ready,
	input wire logic                  flush
);
	timeunit 1ns;
	timeprecision 1ps;

	// request held with the same address until ack
	stb_hold: assert property (@(posedge clk) disable iff (!arst_n)
		wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr))
		else $error("stb dropped or adr changed before ack");

	// one idle cycle after ack
	stb_drop: assert property (@(posedge clk) disable iff (!arst_n)
		wb_req.stb && wb_rsp.ack |=> !wb_req.stb)
		else $error("stb still high in the cycle after ack");

	// a flush may empty the decode queue under a stalled packet
	pack_stable: assert property (@(posedge clk) disable iff (!arst_n)
		dispatch_valid && !dispatch_ready && !flush |=>
		dispatch_valid && $stable(dispatch_pack))
		else $error("dispatch packet changed while stalled");

endmodule

`default_nettype wire

// ==== testbench/frontend_stim.txt ====
# M byte_addr word | F packets_before_flush redirect_pc
# E pc fu src1 src2 dest imm alu_func halt csr_op illegal (pc imm hex, rest decimal)
M 00000000 123450b7
M 00000004 fff08113
M 00000008 002081b3
M 0000000c 40118233
M 00000010 022082b3
M 00000014 0080a303
M 00000018 0020a623
M 0000001c 00208863
M 00000020 008000ef
M 00000024 30009373
M 00000028 ffffffff
M 0000002c 10500073
M 00000040 0051c413
M 00000044 40345493
M 00000048 00008067
M 00000080 07f17513
M 00000084 0020a5b3
M 00000088 10500073
E 00000000 0 0 0 1 12345000 0 0 0 0
E 00000004 0 1 0 2 ffffffff 0 0 0 0
E 00000008 0 1 2 3 00000000 0 0 0 0
E 0000000c 0 3 1 4 00000000 1 0 0 0
E 00000010 1 1 2 5 00000000 10 0 0 0
E 00000014 2 1 0 6 00000008 0 0 0 0
E 00000018 2 1 2 0 0000000c 0 0 0 0
E 0000001c 3 1 2 0 00000010 0 0 0 0
E 00000020 3 0 0 1 00000008 0 0 0 0
E 00000024 0 0 0 0 00000000 0 0 1 0
E 00000028 0 0 0 0 00000000 0 0 0 1
E 0000002c 0 0 0 0 00000000 0 1 0 0
E 00000040 0 3 0 8 00000005 6 0 0 0
E 00000044 0 8 0 9 00000403 9 0 0 0
E 00000048 3 0 0 0 00000000 0 0 0 0
E 00000080 0 2 0 10 0000007f 4 0 0 0
E 00000084 0 1 2 11 00000000 2 0 0 0
E 00000088 0 0 0 0 00000000 0 1 0 0
F 12 00000040
F 15 00000080

// ==== testbench/frontend_tb.sv ====
/*
 * stimulus and expected packets come from testbench/frontend_stim.txt
 * memory model answers after 0 to 2 wait cycles, unlisted words get a fill
 * a flush waits 8 cycles after its packet count, ready low unless halted
 */
`default_nettype none

module frontend_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic arst_n;
	logic flush;
	logic dispatch_ready;
	logic [rv_pkg::xlen-1:0] redirect_pc;
	rv_pkg::wb_req_t wb_req;
	rv_pkg::wb_rsp_t wb_rsp;
	rv_pkg::decoded_pack_t dispatch_pack;
	logic dispatch_valid;
	logic halted;

	logic [31:0] mem [logic [31:0]];
	int flush_after [$];
	logic [31:0] flush_pc [$];
	integer seed = 23750;
	int accepted;
	int flush_idx;
	int gap;
	int wait_left;
	logic active;

	frontend_top dut0 (
		.clk, .arst_n, .wb_rsp, .flush, .redirect_pc, .dispatch_ready,
		.wb_req, .dispatch_pack, .dispatch_valid, .halted
	);

	frontend_checker chk0 (
		.clk, .arst_n, .dispatch_pack, .dispatch_valid, .dispatch_ready,
		.halted, .flush, .wb_req
	);

	// all signals of interest are top level ports
	bind frontend_top frontend_props props0 (
		.clk, .arst_n, .wb_req, .wb_rsp, .dispatch_pack,
		.dispatch_valid, .dispatch_ready, .flush
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] read_word(input logic [31:0] adr);
		if (mem.exists(adr))
			return mem[adr];
		return adr ^ 32'h5a5a_c3c3;
	endfunction

	// wishbone slave, one request at a time
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_rsp <= '0;
			active <= 1'b0;
			wait_left <= 0;
		end else if (wb_rsp.ack) begin
			wb_rsp <= '0;
			active <= 1'b0;
		end else if (wb_req.cyc && wb_req.stb) begin
			if (!active) begin
				active <= 1'b1;
				wait_left <= $unsigned($random(seed)) % 3;
			end else if (wait_left == 0) begin
				wb_rsp <= '{ack: 1'b1, dat: read_word(wb_req.adr)};
			end else begin
				wait_left <= wait_left - 1;
			end
		end
	end

	// random ready, flush after the commanded packet count
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dispatch_ready <= 1'b0;
			flush <= 1'b0;
			redirect_pc <= '0;
			accepted = 0;
			flush_idx = 0;
			gap = 0;
		end else begin
			flush <= 1'b0;
			if (dispatch_valid && dispatch_ready)
				accepted++;
			if (flush_idx < flush_after.size() && accepted == flush_after[flush_idx]) begin
				// a halted core must stay silent even with ready high
				dispatch_ready <= halted;
				if (gap < 8) begin
					gap++;
				end else begin
					flush <= 1'b1;
					redirect_pc <= flush_pc[flush_idx];
					flush_idx++;
					gap = 0;
				end
			end else begin
				dispatch_ready <= ($random(seed) & 3) != 0;
			end
		end
	end

	task automatic load_stim();
		int fd;
		int n;
		string line;
		logic [31:0] a;
		logic [31:0] w;
		int fu;
		int s1;
		int s2;
		int d;
		int op;
		int h;
		int c;
		int il;
		rv_pkg::decoded_pack_t rec;
		fd = $fopen("testbench/frontend_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/frontend_stim.txt");
			return;
		end
		while ($fgets(line, fd)) begin
			if (line.len() == 0) begin
				// blank
			end else if (line[0] == "M") begin
				n = $sscanf(line, "M %h %h", a, w);
				mem[a] = w;
			end else if (line[0] == "E") begin
				n = $sscanf(line, "E %h %d %d %d %d %h %d %d %d %d",
					a, fu, s1, s2, d, w, op, h, c, il);
				rec = '0;
				rec.pc = a;
				rec.fu = rv_pkg::fu_e'(fu);
				rec.arch_reg = '{src1: s1[4:0], src2: s2[4:0], dest: d[4:0]};
				rec.imm = w;
				rec.alu_func = rv_pkg::alu_func_e'(op);
				rec.halt = h[0];
				rec.csr_op = c[0];
				rec.illegal = il[0];
				chk0.add_expected(rec);
			end else if (line[0] == "F") begin
				n = $sscanf(line, "F %d %h", d, a);
				flush_after.push_back(d);
				flush_pc.push_back(a);
			end
		end
		$fclose(fd);
	endtask

	initial begin
		int limit;
		int cycles;
		int quiet;
		bit timed_out;
		arst_n = 1'b0;
		flush = 1'b0;
		dispatch_ready = 1'b0;
		redirect_pc = '0;
		wb_rsp = '0;
		cycles = 0;
		quiet = 0;
		timed_out = 1'b0;
		load_stim();
		limit = 60 * chk0.pending() + 200;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		// done once every packet is in and the core sits halted
		forever begin
			@(posedge clk);
			cycles++;
			if (chk0.pending() == 0 && halted)
				quiet++;
			else
				quiet = 0;
			if (quiet == 20)
				break;
			if (cycles >= limit) begin
				timed_out = 1'b1;
				$display("timeout: run stopped after %0d cycles", cycles);
				break;
			end
		end
		chk0.report();
		if (timed_out || chk0.errors != 0)
			$display("Simulation finished: FAIL");
		else
			$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire
